// ==== Bender.yml ====
package:
  name: fp_cast

sources:
  - files:
      - logic/fp_cast_pkg.sv
      - logic/fp_cast_pipe_stage.sv
      - logic/fp_cast_normalize.sv
      - logic/fp_cast_align.sv
      - logic/fp_cast_round.sv
      - logic/fp_cast_result.sv
      - logic/fp_cast_top.sv
  - target: test
    files:
      - verif/fp_cast_clk_gen.sv
      - verif/fp_cast_tb.sv

// ==== fp_cast.f ====
logic/fp_cast_pkg.sv
logic/fp_cast_pipe_stage.sv
logic/fp_cast_normalize.sv
logic/fp_cast_align.sv
logic/fp_cast_round.sv
logic/fp_cast_result.sv
logic/fp_cast_top.sv
verif/fp_cast_clk_gen.sv
verif/fp_cast_tb.sv

// ==== logic/fp_cast_align.sv ====
// ---------------------------------------------------------------------
// rebias, range check and alignment ahead of rounding
// int overflow is judged on the exponent alone
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fp_cast_align
  import fp_cast_pkg::*;
(
  input  norm_t                norm_i,
  output logic [INT_WIDTH-1:0] pre_round_o,
  output logic [1:0]           round_sticky_o,
  output logic                 of_before_o,
  output logic                 uf_before_o
);

  localparam int SHIFT_WIDTH = 2 * MAN_WIDTH + 1;
  localparam int FP_STICKY   = 2 * MAN_WIDTH - FP32_MAN_BITS - 1;  // below fraction and round
  localparam int INT_STICKY  = 2 * MAN_WIDTH - INT_WIDTH;

  logic                        dst_is_int;
  logic signed [EXP_WIDTH-1:0] src_exp;
  logic signed [EXP_WIDTH-1:0] dst_exp;
  logic signed [EXP_WIDTH-1:0] dst_bias;
  logic signed [EXP_WIDTH-1:0] dst_man_bits;
  logic signed [EXP_WIDTH-1:0] exp_max;
  logic signed [EXP_WIDTH-1:0] int_max_exp;
  logic [EXP_WIDTH-1:0]        final_exp;
  logic [EXP_WIDTH-1:0]        shamt;
  logic [SHIFT_WIDTH-1:0]      preshift;
  logic [SHIFT_WIDTH-1:0]      shifted;
  logic [FP32_MAN_BITS-1:0]    final_mant;
  logic [INT_WIDTH-1:0]        final_int;
  logic [1:0]                  fp_rs;
  logic [1:0]                  int_rs;

  assign dst_is_int = (norm_i.op == F2I);
  assign src_exp    = signed'(norm_i.exp);

  assign dst_bias     = (norm_i.dst_fmt == FP16) ? EXP_WIDTH'(FP16_BIAS) : EXP_WIDTH'(FP32_BIAS);
  assign dst_man_bits = (norm_i.dst_fmt == FP16) ? EXP_WIDTH'(FP16_MAN_BITS)
                                                 : EXP_WIDTH'(FP32_MAN_BITS);
  assign exp_max      = (norm_i.dst_fmt == FP16) ? EXP_WIDTH'((1 << FP16_EXP_BITS) - 1)
                                                 : EXP_WIDTH'((1 << FP32_EXP_BITS) - 1);
  assign int_max_exp  = norm_i.op_mod ? EXP_WIDTH'(INT_WIDTH) : EXP_WIDTH'(INT_WIDTH - 1);
  assign dst_exp      = src_exp + dst_bias;

  // ---------------------------------------------------------------------
  // shift amount and range handling
  // ---------------------------------------------------------------------
  always_comb begin : cast_value
    final_exp   = dst_exp;
    preshift    = SHIFT_WIDTH'(norm_i.mant) << (MAN_WIDTH + 1);
    shamt       = EXP_WIDTH'(FP32_MAN_BITS) - dst_man_bits;  // narrow fraction sits low
    of_before_o = 1'b0;
    uf_before_o = 1'b0;
    if (dst_is_int) begin
      shamt = EXP_WIDTH'(INT_WIDTH - 1) - src_exp;
      if (src_exp >= int_max_exp) begin
        shamt       = '0;
        of_before_o = 1'b1;
      end else if (src_exp < -1) begin  // below one half
        shamt       = EXP_WIDTH'(INT_WIDTH + 1);
        uf_before_o = 1'b1;
      end
    end else if (dst_exp >= exp_max || norm_i.is_inf) begin
      final_exp   = exp_max - 1;  // largest finite, round bits set
      preshift    = '1;
      of_before_o = 1'b1;
    end else if (dst_exp < 1 && dst_exp >= -dst_man_bits) begin
      final_exp   = '0;
      shamt       = shamt + 1 - dst_exp;
      uf_before_o = 1'b1;
    end else if (dst_exp < -dst_man_bits) begin
      final_exp   = '0;
      shamt       = shamt + 2 + dst_man_bits;  // everything into sticky
      uf_before_o = 1'b1;
    end
  end

  assign shifted = preshift >> shamt;

  assign {final_mant, fp_rs[1]} = shifted[2*MAN_WIDTH-1 -: FP32_MAN_BITS+1];
  assign {final_int, int_rs[1]} = shifted[2*MAN_WIDTH -: INT_WIDTH+1];
  assign fp_rs[0]               = |shifted[FP_STICKY-1:0];
  assign int_rs[0]              = |shifted[INT_STICKY-1:0];

  always_comb begin : pack_abs
    if (dst_is_int) begin
      pre_round_o = final_int;
    end else if (norm_i.dst_fmt == FP16) begin
      pre_round_o = INT_WIDTH'({final_exp[FP16_EXP_BITS-1:0], final_mant[FP16_MAN_BITS-1:0]});
    end else begin
      pre_round_o = INT_WIDTH'({final_exp[FP32_EXP_BITS-1:0], final_mant});
    end
  end

  assign round_sticky_o = dst_is_int ? int_rs : fp_rs;

endmodule

`default_nettype wire

// ==== logic/fp_cast_normalize.sv ====
// ---------------------------------------------------------------------
// combinational front end of the cast unit
// class bits are only set for float sources
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fp_cast_normalize
  import fp_cast_pkg::*;
(
  input  cast_req_t req_i,
  output norm_t     norm_o
);

  localparam int LZC_WIDTH = $clog2(MAN_WIDTH + 1);

  logic                     src_is_int;
  logic                     fp_sign;
  logic [FP32_EXP_BITS-1:0] fp_exp;      // fp16 exponent zero-extended
  logic [FP32_MAN_BITS-1:0] fp_man;      // fp16 fraction left-aligned
  logic                     exp_is_max;
  logic                     exp_is_zero;
  logic                     man_is_zero;
  logic [EXP_WIDTH-1:0]     src_bias;
  logic                     int_sign;
  logic [INT_WIDTH-1:0]     int_mag;
  logic [MAN_WIDTH-1:0]     fp_mant;
  logic [MAN_WIDTH-1:0]     enc_mant;
  logic [LZC_WIDTH-1:0]     lzc;
  logic [EXP_WIDTH-1:0]     fp_exp_unb;
  logic [EXP_WIDTH-1:0]     int_exp_unb;

  assign src_is_int = (req_i.op == I2F);

  // ---------------------------------------------------------------------
  // float source decode
  // ---------------------------------------------------------------------
  always_comb begin : fmt_select
    if (req_i.src_fmt == FP16) begin
      fp_sign    = req_i.operand.fp16.val.sign;
      fp_exp     = FP32_EXP_BITS'(req_i.operand.fp16.val.exponent);
      fp_man     = FP32_MAN_BITS'(req_i.operand.fp16.val.mantissa)
                   << (FP32_MAN_BITS - FP16_MAN_BITS);
      exp_is_max = &req_i.operand.fp16.val.exponent;
      src_bias   = EXP_WIDTH'(FP16_BIAS);
    end else begin
      fp_sign    = req_i.operand.fp32.sign;
      fp_exp     = req_i.operand.fp32.exponent;
      fp_man     = req_i.operand.fp32.mantissa;
      exp_is_max = &req_i.operand.fp32.exponent;
      src_bias   = EXP_WIDTH'(FP32_BIAS);
    end
  end

  assign exp_is_zero = (fp_exp == '0);
  assign man_is_zero = (fp_man == '0);
  assign fp_mant     = MAN_WIDTH'({~exp_is_zero, fp_man}) << (MAN_WIDTH - 1 - FP32_MAN_BITS);

  // magnitude of the integer source
  assign int_sign = req_i.operand.int32[INT_WIDTH-1] & ~req_i.op_mod;
  assign int_mag  = int_sign ? -req_i.operand.int32 : req_i.operand.int32;

  assign enc_mant = src_is_int ? int_mag : fp_mant;

  // ---------------------------------------------------------------------
  // leading-zero count and normalization
  // ---------------------------------------------------------------------
  always_comb begin : lzc_count
    lzc = LZC_WIDTH'(MAN_WIDTH);  // all zero
    for (int i = 0; i < MAN_WIDTH; i++) begin
      if (enc_mant[i]) lzc = LZC_WIDTH'(MAN_WIDTH - 1 - i);
    end
  end

  // subnormals sit one exponent above their raw field
  assign fp_exp_unb  = EXP_WIDTH'(fp_exp) + EXP_WIDTH'(exp_is_zero) - src_bias
                       - EXP_WIDTH'(lzc);
  assign int_exp_unb = EXP_WIDTH'(MAN_WIDTH - 1) - EXP_WIDTH'(lzc);

  always_comb begin : pack_norm
    norm_o.sign          = src_is_int ? int_sign : fp_sign;
    norm_o.exp           = src_is_int ? int_exp_unb : fp_exp_unb;
    norm_o.mant          = enc_mant << lzc;
    norm_o.is_zero       = ~src_is_int & exp_is_zero & man_is_zero;
    norm_o.is_inf        = ~src_is_int & exp_is_max & man_is_zero;
    norm_o.is_nan        = ~src_is_int & exp_is_max & ~man_is_zero;
    norm_o.is_signalling = ~src_is_int & exp_is_max & ~man_is_zero & ~fp_man[FP32_MAN_BITS-1];
    norm_o.mant_is_zero  = (enc_mant == '0);
    norm_o.op            = req_i.op;
    norm_o.op_mod        = req_i.op_mod;
    norm_o.dst_fmt       = req_i.dst_fmt;
    norm_o.rnd_mode      = req_i.rnd_mode;
  end

  // lzc and shifter together must leave the leading one on top
  a_mant_normalized: assert final (norm_o.mant_is_zero || norm_o.mant[MAN_WIDTH-1])
    else $error("normalized mantissa lacks its leading one");

endmodule

`default_nettype wire

// ==== logic/fp_cast_pipe_stage.sv ====
// ---------------------------------------------------------------------
// one-entry valid/ready register slice
// ready_o depends combinationally on ready_i
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fp_cast_pipe_stage #(
  parameter int unsigned DataWidth = 32
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic [DataWidth-1:0] data_i,
  input  logic                 valid_i,
  output logic                 ready_o,
  output logic [DataWidth-1:0] data_o,
  output logic                 valid_o,
  input  logic                 ready_i
);

  logic [DataWidth-1:0] data_q;
  logic                 valid_q;

  // accept when empty or when the entry leaves this cycle
  assign ready_o = ~valid_q | ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

  assign data_o  = data_q;
  assign valid_o = valid_q;

  // a stalled entry must neither drop nor change
  a_hold_stalled: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o))
    else $error("pipe stage changed a stalled entry");

endmodule

`default_nettype wire

// ==== logic/fp_cast_pkg.sv ====
// ---------------------------------------------------------------------
// types and constants shared by the cast unit
// only fp32, fp16 and 32-bit integers are supported
// fp16 results occupy the low half of the 32-bit result word
// ---------------------------------------------------------------------
`default_nettype none

package fp_cast_pkg;

  localparam int INT_WIDTH = 32;
  localparam int MAN_WIDTH = 32;  // internal mantissa, wide enough for an int
  localparam int EXP_WIDTH = 10;  // signed unbiased exponent

  localparam int FP32_EXP_BITS = 8;
  localparam int FP32_MAN_BITS = 23;
  localparam int FP32_BIAS     = 127;
  localparam int FP16_EXP_BITS = 5;
  localparam int FP16_MAN_BITS = 10;
  localparam int FP16_BIAS     = 15;

  localparam logic [31:0] FP32_QNAN = 32'h7FC0_0000;  // canonical quiet nan
  localparam logic [15:0] FP16_QNAN = 16'h7E00;

  typedef enum logic {FP32, FP16} fp_fmt_e;
  typedef enum logic [1:0] {F2F, F2I, I2F} cast_op_e;
  typedef enum logic [2:0] {RNE, RTZ, RDN, RUP, RMM} rnd_mode_e;

  typedef struct packed {
    logic nv;
    logic of;
    logic uf;
    logic nx;
  } status_t;

  typedef struct packed {
    logic                     sign;
    logic [FP32_EXP_BITS-1:0] exponent;
    logic [FP32_MAN_BITS-1:0] mantissa;
  } fp32_t;

  typedef struct packed {
    logic                     sign;
    logic [FP16_EXP_BITS-1:0] exponent;
    logic [FP16_MAN_BITS-1:0] mantissa;
  } fp16_t;

  // one operand word, read as fp32, as fp16 in the low half or as int32
  typedef union packed {
    fp32_t fp32;
    struct packed {
      logic [15:0] pad;
      fp16_t       val;
    } fp16;
    logic [INT_WIDTH-1:0] int32;
  } operand_u;

  typedef struct packed {
    operand_u  operand;
    cast_op_e  op;
    logic      op_mod;    // 1 selects unsigned integer
    fp_fmt_e   src_fmt;
    fp_fmt_e   dst_fmt;
    rnd_mode_e rnd_mode;
  } cast_req_t;

  typedef struct packed {
    logic [31:0] result;
    status_t     status;
  } cast_resp_t;

  typedef struct packed {
    logic                 sign;
    logic [EXP_WIDTH-1:0] exp;   // two's complement, unbiased
    logic [MAN_WIDTH-1:0] mant;  // leading one at the top bit
    logic                 is_zero;
    logic                 is_inf;
    logic                 is_nan;
    logic                 is_signalling;
    logic                 mant_is_zero;
    cast_op_e             op;
    logic                 op_mod;
    fp_fmt_e              dst_fmt;
    rnd_mode_e            rnd_mode;
  } norm_t;

endpackage

`default_nettype wire

// ==== logic/fp_cast_result.sv ====
// ---------------------------------------------------------------------
// final result and flags
// integer specials saturate and raise nv
// float nan results are always the canonical quiet nan
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fp_cast_result
  import fp_cast_pkg::*;
(
  input  norm_t                norm_i,
  input  logic [INT_WIDTH-1:0] rounded_i,
  input  logic [1:0]           round_sticky_i,
  input  logic                 of_before_i,
  input  logic                 uf_before_i,
  output cast_resp_t           resp_o
);

  logic                 src_is_int;
  logic                 dst_is_int;
  logic                 of_after;
  logic                 uf_after;
  logic [31:0]          fp_regular;
  logic [31:0]          fp_special;
  logic                 fp_is_special;
  status_t              fp_status;
  logic [INT_WIDTH-1:0] int_regular;
  logic [INT_WIDTH-1:0] int_special;
  logic                 int_is_special;
  status_t              int_status;

  assign src_is_int = (norm_i.op == I2F);
  assign dst_is_int = (norm_i.op == F2I);

  // ---------------------------------------------------------------------
  // float destination
  // ---------------------------------------------------------------------
  always_comb begin : fp_pack
    if (norm_i.dst_fmt == FP16) begin
      uf_after   = (rounded_i[FP16_MAN_BITS +: FP16_EXP_BITS] == '0);
      of_after   = &rounded_i[FP16_MAN_BITS +: FP16_EXP_BITS];
      fp_regular = 32'({norm_i.sign, rounded_i[FP16_EXP_BITS+FP16_MAN_BITS-1:0]});
      fp_special = 32'({norm_i.sign, {FP16_EXP_BITS{norm_i.is_inf}}, FP16_MAN_BITS'(0)});
      if (norm_i.is_nan) fp_special = 32'(FP16_QNAN);
    end else begin
      uf_after   = (rounded_i[FP32_MAN_BITS +: FP32_EXP_BITS] == '0);
      of_after   = &rounded_i[FP32_MAN_BITS +: FP32_EXP_BITS];
      fp_regular = {norm_i.sign, rounded_i[FP32_EXP_BITS+FP32_MAN_BITS-1:0]};
      fp_special = {norm_i.sign, {FP32_EXP_BITS{norm_i.is_inf}}, FP32_MAN_BITS'(0)};
      if (norm_i.is_nan) fp_special = FP32_QNAN;
    end
    if (src_is_int && norm_i.mant_is_zero) fp_regular = '0;  // integer zero
  end

  assign fp_is_special = norm_i.is_zero | norm_i.is_inf | norm_i.is_nan;

  always_comb begin : fp_flags
    fp_status = '0;
    if (fp_is_special) begin
      fp_status.nv = norm_i.is_signalling;
    end else begin
      fp_status.nv = src_is_int & (of_before_i | of_after);  // int too big for the format
      fp_status.of = ~src_is_int & (of_before_i | of_after);
      fp_status.nx = (|round_sticky_i) | fp_status.of;
      fp_status.uf = uf_before_i & uf_after & fp_status.nx;
    end
  end

  // ---------------------------------------------------------------------
  // integer destination
  // ---------------------------------------------------------------------
  assign int_regular = norm_i.sign ? -rounded_i : rounded_i;

  always_comb begin : int_saturate
    int_special = {norm_i.op_mod, {(INT_WIDTH-1){1'b1}}};  // positive max
    if (norm_i.sign && !norm_i.is_nan) int_special = ~int_special;
  end

  assign int_is_special = norm_i.is_nan | norm_i.is_inf | of_before_i
                        | (norm_i.sign & norm_i.op_mod & (int_regular != '0));

  always_comb begin : int_flags
    int_status    = '0;
    int_status.nv = int_is_special;
    int_status.nx = ~int_is_special & (|round_sticky_i);
  end

  // final selection
  always_comb begin : select_resp
    if (dst_is_int) begin
      resp_o.result = int_is_special ? int_special : int_regular;
      resp_o.status = int_status;
    end else begin
      resp_o.result = fp_is_special ? fp_special : fp_regular;
      resp_o.status = fp_status;
    end
  end

endmodule

`default_nettype wire

// ==== logic/fp_cast_round.sv ====
// ---------------------------------------------------------------------
// rounds a magnitude by one ulp from round and sticky bits
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fp_cast_round
  import fp_cast_pkg::*;
(
  input  logic [INT_WIDTH-1:0] abs_i,
  input  logic                 sign_i,
  input  logic [1:0]           round_sticky_i,  // {round, sticky}
  input  rnd_mode_e            rnd_mode_i,
  output logic [INT_WIDTH-1:0] abs_o
);

  logic round_up;

  always_comb begin : round_decision
    unique case (rnd_mode_i)
      RNE:     round_up = round_sticky_i[1] & (round_sticky_i[0] | abs_i[0]);  // ties to even
      RTZ:     round_up = 1'b0;
      RDN:     round_up = (|round_sticky_i) & sign_i;
      RUP:     round_up = (|round_sticky_i) & ~sign_i;
      RMM:     round_up = round_sticky_i[1];  // ties away
      default: round_up = 1'b0;
    endcase
  end

  // carry out of the fraction bumps the exponent
  assign abs_o = abs_i + INT_WIDTH'(round_up);

endmodule

`default_nettype wire

// ==== logic/fp_cast_top.sv ====
// ---------------------------------------------------------------------
// fp32/fp16/int32 cast unit with two register stages
// latency two cycles, up to two requests in flight
// there is no input register, so req_i feeds logic directly
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fp_cast_top
  import fp_cast_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  cast_req_t  req_i,
  input  logic       req_valid_i,
  output logic       req_ready_o,
  output cast_resp_t resp_o,
  output logic       resp_valid_o,
  input  logic       resp_ready_i
);

  norm_t                norm_d;
  norm_t                norm_q;
  logic                 norm_valid;
  logic                 norm_ready;
  logic [INT_WIDTH-1:0] pre_round;
  logic [INT_WIDTH-1:0] rounded;
  logic [1:0]           round_sticky;
  logic                 of_before;
  logic                 uf_before;
  cast_resp_t           resp_d;

  fp_cast_normalize i_normalize (
    .req_i  ( req_i  ),
    .norm_o ( norm_d )
  );

  // stage 1 after normalization
  fp_cast_pipe_stage #(
    .DataWidth ( $bits(norm_t) )
  ) i_norm_stage (
    .clk_i   ( clk_i       ),
    .rst_n_i ( rst_n_i     ),
    .data_i  ( norm_d      ),
    .valid_i ( req_valid_i ),
    .ready_o ( req_ready_o ),
    .data_o  ( norm_q      ),
    .valid_o ( norm_valid  ),
    .ready_i ( norm_ready  )
  );

  fp_cast_align i_align (
    .norm_i         ( norm_q       ),
    .pre_round_o    ( pre_round    ),
    .round_sticky_o ( round_sticky ),
    .of_before_o    ( of_before    ),
    .uf_before_o    ( uf_before    )
  );

  fp_cast_round i_round (
    .abs_i          ( pre_round       ),
    .sign_i         ( norm_q.sign     ),
    .round_sticky_i ( round_sticky    ),
    .rnd_mode_i     ( norm_q.rnd_mode ),
    .abs_o          ( rounded         )
  );

  fp_cast_result i_result (
    .norm_i         ( norm_q       ),
    .rounded_i      ( rounded      ),
    .round_sticky_i ( round_sticky ),
    .of_before_i    ( of_before    ),
    .uf_before_i    ( uf_before    ),
    .resp_o         ( resp_d       )
  );

  // stage 2 at the output
  fp_cast_pipe_stage #(
    .DataWidth ( $bits(cast_resp_t) )
  ) i_out_stage (
    .clk_i   ( clk_i        ),
    .rst_n_i ( rst_n_i      ),
    .data_i  ( resp_d       ),
    .valid_i ( norm_valid   ),
    .ready_o ( norm_ready   ),
    .data_o  ( resp_o       ),
    .valid_o ( resp_valid_o ),
    .ready_i ( resp_ready_i )
  );

endmodule

`default_nettype wire

// ==== verif/fp_cast_clk_gen.sv ====
// ----------------------------------------------------------------------
// clock and reset source for the cast unit testbench
// reset is released 1 ns after the last reset edge
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fp_cast_clk_gen #(
  parameter int PeriodNs    = 8,
  parameter int ResetCycles = 3
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// ==== verif/fp_cast_tb.sv ====
// ----------------------------------------------------------------------
// directed testbench for the cast unit, stops at the first mismatch
// inputs change 1 ns after the rising edge, outputs are read at the falling edge
// burst values are small xorshift integers that fp32 holds exactly
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fp_cast_tb
  import fp_cast_pkg::*;
();

  localparam int          DRIVE_DELAY = 1;
  localparam int          BURST_LEN   = 6;
  localparam int          MAX_CYCLES  = 400;  // tests take under 200 cycles
  localparam logic [31:0] SEED        = 32'h043311e6;

  logic        clk;
  logic        rst_n;
  cast_req_t   req;
  logic        req_valid;
  logic        req_ready;
  cast_resp_t  resp;
  logic        resp_valid;
  logic        resp_ready;

  int unsigned cycle_count = 0;
  logic [31:0] rng_state;
  cast_req_t   burst_req [BURST_LEN];
  logic [31:0] burst_exp [BURST_LEN];

  fp_cast_clk_gen i_clk_gen (
    .clk_o   ( clk   ),
    .rst_n_o ( rst_n )
  );

  fp_cast_top fp_cast_top_i (
    .clk_i        ( clk        ),
    .rst_n_i      ( rst_n      ),
    .req_i        ( req        ),
    .req_valid_i  ( req_valid  ),
    .req_ready_o  ( req_ready  ),
    .resp_o       ( resp       ),
    .resp_valid_o ( resp_valid ),
    .resp_ready_i ( resp_ready )
  );

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic compare_result(input logic [31:0] got, input logic [31:0] exp,
                                input string what);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED at time %0t: %s result %08h, expected %08h",
                         $time, what, got, exp));
    end
  endtask

  task automatic compare_status(input status_t got, input status_t exp, input string what);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED at time %0t: %s flags nv/of/uf/nx %04b, expected %04b",
                         $time, what, got, exp));
    end
  endtask

  function automatic status_t flags(input logic nv, input logic of, input logic uf,
                                    input logic nx);
    status_t s;
    s.nv = nv;
    s.of = of;
    s.uf = uf;
    s.nx = nx;
    return s;
  endfunction

  function automatic cast_req_t make_req(input cast_op_e op, input logic op_mod,
                                         input fp_fmt_e src, input fp_fmt_e dst,
                                         input rnd_mode_e rnd, input logic [31:0] operand);
    cast_req_t r;
    r.operand.int32 = operand;
    r.op            = op;
    r.op_mod        = op_mod;
    r.src_fmt       = src;
    r.dst_fmt       = dst;
    r.rnd_mode      = rnd;
    return r;
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // exact fp32 encoding of an integer below 2^24
  function automatic logic [31:0] int_to_fp32(input logic [31:0] v);
    logic [31:0] mag;
    int          msb;
    mag = v[31] ? -v : v;
    msb = 0;
    for (int i = 0; i < 32; i++) begin
      if (mag[i]) msb = i;
    end
    if (mag == 0) return 32'h0;
    return {v[31], 8'(127 + msb), 23'(mag << (23 - msb))};
  endfunction

  task automatic wait_accept;
    @(negedge clk);
    while (!req_ready) @(negedge clk);
    @(posedge clk);  // transfer edge
    #DRIVE_DELAY;
    req_valid = 1'b0;
  endtask

  task automatic issue(input cast_req_t r);
    @(posedge clk);
    #DRIVE_DELAY;
    req       = r;
    req_valid = 1'b1;
    wait_accept();
  endtask

  task automatic take_resp(output cast_resp_t r);
    @(negedge clk);
    while (!(resp_valid && resp_ready)) @(negedge clk);
    r = resp;
    @(posedge clk);
  endtask

  task automatic cast_and_check(input cast_req_t r, input logic [31:0] exp_result,
                                input status_t exp_status, input string what);
    cast_resp_t got;
    issue(r);
    take_resp(got);
    compare_result(got.result, exp_result, what);
    compare_status(got.status, exp_status, what);
  endtask

  // ----------------------------------------------------------------------
  // directed tests
  // ----------------------------------------------------------------------
  task automatic exact_casts;
    cast_and_check(make_req(I2F, 1'b0, FP32, FP32, RNE, 32'd5), 32'h40A00000,
                   flags(0, 0, 0, 0), "i2f 5");
    cast_and_check(make_req(I2F, 1'b0, FP32, FP32, RNE, 32'hFFFFFFFF), 32'hBF800000,
                   flags(0, 0, 0, 0), "i2f -1");
    cast_and_check(make_req(F2F, 1'b0, FP32, FP16, RNE, 32'h3FC00000), 32'h00003E00,
                   flags(0, 0, 0, 0), "fp32 1.5 to fp16");
    cast_and_check(make_req(F2F, 1'b0, FP16, FP32, RNE, 32'h0000C000), 32'hC0000000,
                   flags(0, 0, 0, 0), "fp16 -2.0 to fp32");
  endtask

  task automatic rounding_modes;
    cast_and_check(make_req(F2I, 1'b0, FP32, FP32, RNE, 32'h40200000), 32'd2,
                   flags(0, 0, 0, 1), "f2i 2.5 rne");
    cast_and_check(make_req(F2I, 1'b0, FP32, FP32, RTZ, 32'h40200000), 32'd2,
                   flags(0, 0, 0, 1), "f2i 2.5 rtz");
    cast_and_check(make_req(F2I, 1'b0, FP32, FP32, RDN, 32'h40200000), 32'd2,
                   flags(0, 0, 0, 1), "f2i 2.5 rdn");
    cast_and_check(make_req(F2I, 1'b0, FP32, FP32, RUP, 32'h40200000), 32'd3,
                   flags(0, 0, 0, 1), "f2i 2.5 rup");
    cast_and_check(make_req(F2I, 1'b0, FP32, FP32, RMM, 32'h40200000), 32'd3,
                   flags(0, 0, 0, 1), "f2i 2.5 rmm");
    cast_and_check(make_req(F2I, 1'b0, FP32, FP32, RTZ, 32'hC0200000), 32'hFFFFFFFE,
                   flags(0, 0, 0, 1), "f2i -2.5 rtz");
    cast_and_check(make_req(F2I, 1'b0, FP32, FP32, RDN, 32'hC0200000), 32'hFFFFFFFD,
                   flags(0, 0, 0, 1), "f2i -2.5 rdn");
  endtask

  task automatic special_values;
    cast_and_check(make_req(F2F, 1'b0, FP32, FP16, RNE, 32'h7FC00000), 32'h00007E00,
                   flags(0, 0, 0, 0), "qnan to fp16");
    cast_and_check(make_req(F2F, 1'b0, FP32, FP16, RNE, 32'h7F800001), 32'h00007E00,
                   flags(1, 0, 0, 0), "snan to fp16");
    cast_and_check(make_req(F2F, 1'b0, FP32, FP16, RNE, 32'h80000000), 32'h00008000,
                   flags(0, 0, 0, 0), "-0.0 to fp16");
    cast_and_check(make_req(F2I, 1'b0, FP32, FP32, RNE, 32'h7F800000), 32'h7FFFFFFF,
                   flags(1, 0, 0, 0), "f2i +inf signed");
    cast_and_check(make_req(F2I, 1'b1, FP32, FP32, RNE, 32'hBF800000), 32'h00000000,
                   flags(1, 0, 0, 0), "f2i -1.0 unsigned");
  endtask

  task automatic range_limits;
    cast_and_check(make_req(F2F, 1'b0, FP32, FP16, RNE, 32'h501502F9), 32'h00007C00,
                   flags(0, 1, 0, 1), "1e10 to fp16 rne");
    cast_and_check(make_req(F2F, 1'b0, FP32, FP16, RTZ, 32'h501502F9), 32'h00007BFF,
                   flags(0, 1, 0, 1), "1e10 to fp16 rtz");
    cast_and_check(make_req(F2F, 1'b0, FP32, FP16, RNE, 32'h30800000), 32'h00000000,
                   flags(0, 0, 1, 1), "2^-30 to fp16");
    cast_and_check(make_req(I2F, 1'b0, FP32, FP32, RNE, 32'h01000001), 32'h4B800000,
                   flags(0, 0, 0, 1), "i2f 2^24+1");
  endtask

  // ----------------------------------------------------------------------
  // back-pressure bursts
  // ----------------------------------------------------------------------
  task automatic run_burst(input string what);
    cast_resp_t r;
    int         sent;
    logic       stalled;
    sent    = 0;
    stalled = 1'b0;
    #DRIVE_DELAY;
    resp_ready = 1'b0;
    // fill both stages until the input side stalls
    while (!stalled && sent < BURST_LEN) begin
      @(posedge clk);
      #DRIVE_DELAY;
      req       = burst_req[sent];
      req_valid = 1'b1;
      @(negedge clk);
      if (req_ready) begin
        @(posedge clk);
        #DRIVE_DELAY;
        req_valid = 1'b0;
        sent++;
      end else begin
        stalled = 1'b1;
      end
    end
    if (!stalled) fail_run($sformatf("%s: req_ready_o never dropped under back-pressure", what));
    @(posedge clk);
    #DRIVE_DELAY;
    resp_ready = 1'b1;
    fork
      begin
        wait_accept();  // stalled request is still on the bus
        sent++;
        while (sent < BURST_LEN) begin
          issue(burst_req[sent]);
          sent++;
        end
      end
      begin
        for (int i = 0; i < BURST_LEN; i++) begin
          take_resp(r);
          compare_result(r.result, burst_exp[i], $sformatf("%s entry %0d", what, i));
          compare_status(r.status, flags(0, 0, 0, 0), $sformatf("%s entry %0d", what, i));
        end
      end
    join
    @(negedge clk);
    if (resp_valid) fail_run($sformatf("%s: DUT returned more responses than requests", what));
    @(posedge clk);
  endtask

  task automatic backpressure_order;
    logic [31:0] vals [BURST_LEN];
    for (int i = 0; i < BURST_LEN; i++) begin
      rng_state = xorshift32(rng_state);
      vals[i]   = {{16{rng_state[15]}}, rng_state[15:0]};  // signed 16-bit range
    end
    for (int i = 0; i < BURST_LEN; i++) begin
      burst_req[i] = make_req(I2F, 1'b0, FP32, FP32, RNE, vals[i]);
      burst_exp[i] = int_to_fp32(vals[i]);
    end
    run_burst("i2f burst");
    // and back again, must be exact
    for (int i = 0; i < BURST_LEN; i++) begin
      burst_req[i] = make_req(F2I, 1'b0, FP32, FP32, RTZ, int_to_fp32(vals[i]));
      burst_exp[i] = vals[i];
    end
    run_burst("f2i burst");
  endtask

  // ----------------------------------------------------------------------
  // main sequence and timeout
  // ----------------------------------------------------------------------
  initial begin
    req        = '0;
    req_valid  = 1'b0;
    resp_ready = 1'b1;
    rng_state  = SEED;
    wait (rst_n === 1'b1);
    @(negedge clk);
    if (resp_valid !== 1'b0 || req_ready !== 1'b1) begin
      fail_run("handshake outputs are wrong after reset");
    end
    @(posedge clk);
    exact_casts();
    rounding_modes();
    special_values();
    range_limits();
    backpressure_order();
    $display("Test passed");
    $finish;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      fail_run($sformatf("timeout: tests did not finish within %0d cycles", MAX_CYCLES));
    end
  end

endmodule

`default_nettype wire
